/* rename_macros.svh */
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Architectural integer registers, x0 included
`define ARCH_REGS 32

// Physical register pool
`define PHYS_REGS 64

// Reorder-buffer entries
`define ROB_DEPTH 8

// Tag widths derived from the counts
`define ARCH_W $clog2(`ARCH_REGS)
`define PHYS_W $clog2(`PHYS_REGS)
`define ROB_W $clog2(`ROB_DEPTH)

// Major opcode of register-register ALU ops
`define OPCODE_OP 7'b0110011

`endif

/* rename_pkg.sv */
`include "rename_macros.svh"

package rename_pkg;

    // Register and entry tags
    typedef logic [`ARCH_W-1:0] arch_reg_t;
    typedef logic [`PHYS_W-1:0] phys_reg_t;
    typedef logic [`ROB_W-1:0] rob_id_t;

    // R-type layout, both sources live
    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t rs2;
        arch_reg_t rs1;
        logic [2:0] funct3;
        arch_reg_t rd;
        logic [6:0] opcode;
    } r_type_t;

    // I-type layout, rs2 slot holds immediate bits
    typedef struct packed {
        logic [11:0] imm;
        arch_reg_t rs1;
        logic [2:0] funct3;
        arch_reg_t rd;
        logic [6:0] opcode;
    } i_type_t;

    // One fetched word, two decodings picked by opcode
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_word_u;

    // One in-flight instruction
    typedef struct packed {
        arch_reg_t arch_rd;
        phys_reg_t new_preg;
        // Mapping replaced by this rd, freed at commit
        phys_reg_t old_preg;
        logic done;
    } rob_entry_t;

endpackage

/* rename_if.sv */
// Free register pop at rename, push at commit
interface free_list_if;
    import rename_pkg::*;

    logic pop;
    phys_reg_t head_preg;
    logic empty;
    logic push;
    phys_reg_t push_preg;

    // Rename side takes the head register
    modport dispatch (output pop, input head_preg, input empty);
    // Queue side
    modport list (input pop, output head_preg, output empty);
    // Commit side returns the freed mapping
    modport commit (output push, output push_preg);
endinterface

// Reorder-buffer allocation at rename
interface rob_alloc_if;
    import rename_pkg::*;

    logic alloc;
    arch_reg_t arch_rd;
    phys_reg_t new_preg;
    phys_reg_t old_preg;
    logic full;
    rob_id_t tail_id;

    // Rename side opens an entry
    modport dispatch (output alloc, output arch_rd, output new_preg, output old_preg,
                      input full, input tail_id);
    // Buffer side
    modport rob (input alloc, input arch_rd, input new_preg, input old_preg,
                 output full, output tail_id);
endinterface

/* rename_dispatch.sv */
`include "rename_macros.svh"

module rename_dispatch (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  logic [31:0]           inst_word,
    output logic                  inst_ready,
    output logic                  ren_valid,
    output rename_pkg::phys_reg_t ren_rs1_preg,
    output rename_pkg::phys_reg_t ren_rs2_preg,
    output rename_pkg::phys_reg_t ren_rd_preg,
    output rename_pkg::rob_id_t   ren_rob_id,
    output rename_pkg::arch_reg_t rat_rs1,
    output rename_pkg::arch_reg_t rat_rs2,
    output rename_pkg::arch_reg_t rat_rd,
    input  rename_pkg::phys_reg_t rat_rs1_preg,
    input  rename_pkg::phys_reg_t rat_rs2_preg,
    input  rename_pkg::phys_reg_t rat_old_preg,
    output logic                  rat_we,
    output rename_pkg::phys_reg_t rat_new_preg,
    free_list_if.dispatch         fl,
    rob_alloc_if.dispatch         rob
);
    import rename_pkg::*;

    inst_word_u word;
    logic is_r;
    logic has_rd;
    logic live;
    logic xfer;
    phys_reg_t dest_preg;

    // Decode view of the raw word
    assign word = inst_word;
    assign is_r = (word.r.opcode == `OPCODE_OP);

    // rs1 and rd sit at the same bits in both formats
    assign rat_rs1 = word.i.rs1;
    // I-type reads x0, which maps to p0
    assign rat_rs2 = is_r ? word.r.rs2 : '0;
    assign rat_rd = word.i.rd;
    assign has_rd = (rat_rd != '0);

    // Held low for the first cycle out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    // x0 writers need no free register
    assign inst_ready = live & ~rob.full & (~fl.empty | ~has_rd);
    assign xfer = inst_valid & inst_ready;

    // Fresh tag for a real rd, p0 otherwise
    assign dest_preg = has_rd ? fl.head_preg : '0;

    // Free-list pop and map update
    assign fl.pop = xfer & has_rd;
    assign rat_we = xfer & has_rd;
    assign rat_new_preg = dest_preg;

    // Entry open, old mapping is p0 for x0
    assign rob.alloc = xfer;
    assign rob.arch_rd = rat_rd;
    assign rob.new_preg = dest_preg;
    assign rob.old_preg = rat_old_preg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ren_valid <= 1'b0;
        end else begin
            ren_valid <= xfer;
        end
    end

    // Sources sampled before this rd's own map write lands
    always_ff @(posedge clk) begin
        if (xfer) begin
            ren_rs1_preg <= rat_rs1_preg;
            ren_rs2_preg <= rat_rs2_preg;
            ren_rd_preg <= dest_preg;
            ren_rob_id <= rob.tail_id;
        end
    end
endmodule

/* reg_alias_table.sv */
`include "rename_macros.svh"

module reg_alias_table (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    output rename_pkg::phys_reg_t rs1_preg,
    output rename_pkg::phys_reg_t rs2_preg,
    output rename_pkg::phys_reg_t rd_old_preg,
    input  logic                  we,
    input  rename_pkg::phys_reg_t new_preg
);
    import rename_pkg::*;

    // Speculative arch to phys map
    phys_reg_t map [`ARCH_REGS];

    // Combinational lookups
    assign rs1_preg = map[rs1];
    assign rs2_preg = map[rs2];
    // Mapping about to be replaced
    assign rd_old_preg = map[rd];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Identity, xN on pN
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= phys_reg_t'(i);
            end
        end else if (we && rd != '0) begin
            // x0 stays on p0
            map[rd] <= new_preg;
        end
    end
endmodule

/* free_list.sv */
`include "rename_macros.svh"

module free_list (
    input  logic          clk,
    input  logic          arst_n,
    free_list_if.list     fl,
    free_list_if.commit   ret
);
    import rename_pkg::*;

    // Registers above the architectural range start free
    localparam int SLOTS = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W = $clog2(SLOTS);
    localparam int CNT_W = $clog2(SLOTS + 1);

    phys_reg_t slots [SLOTS];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic do_pop;

    assign fl.empty = (count == '0);
    // Next register handed to rename
    assign fl.head_preg = slots[head];

    // Pop guarded against an empty queue
    assign do_pop = fl.pop & ~fl.empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Queue starts full, ascending
            for (int i = 0; i < SLOTS; i++) begin
                slots[i] <= phys_reg_t'(`ARCH_REGS + i);
            end
            head <= '0;
            tail <= '0;
            count <= CNT_W'(SLOTS);
        end else begin
            // Freed mapping back at the tail
            // Never overflows, 32 tags live in 32 slots
            if (ret.push) begin
                slots[tail] <= ret.push_preg;
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            // Same-cycle pop and push cancel
            count <= count + CNT_W'(ret.push) - CNT_W'(do_pop);
        end
    end
endmodule

/* reorder_buffer.sv */
`include "rename_macros.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  arst_n,
    rob_alloc_if.rob              alloc,
    free_list_if.commit           fl,
    input  logic                  done_valid,
    input  rename_pkg::rob_id_t   done_rob_id,
    output logic                  commit_valid,
    output rename_pkg::arch_reg_t commit_arch_rd,
    output rename_pkg::phys_reg_t commit_preg,
    output rename_pkg::phys_reg_t commit_freed_preg
);
    import rename_pkg::*;

    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    rob_entry_t entries [`ROB_DEPTH];
    rob_id_t head;
    rob_id_t tail;
    logic [CNT_W-1:0] count;
    rob_entry_t head_e;

    // Oldest in-flight entry
    assign head_e = entries[head];

    // Allocation status back to rename
    assign alloc.full = (count == CNT_W'(`ROB_DEPTH));
    assign alloc.tail_id = tail;

    // Stale done bits in free slots masked by count
    assign commit_valid = (count != '0) & head_e.done;

    // x0 entries carry p0 in both tags
    assign commit_arch_rd = head_e.arch_rd;
    assign commit_preg = head_e.new_preg;
    assign commit_freed_preg = head_e.old_preg;

    // Return replaced mapping, nothing for x0
    assign fl.push = commit_valid & (head_e.arch_rd != '0);
    assign fl.push_preg = head_e.old_preg;

    always_ff @(posedge clk) begin
        // Completion mark, visible to commit next cycle
        if (done_valid) begin
            entries[done_rob_id].done <= 1'b1;
        end
        // New entry starts not done
        if (alloc.alloc) begin
            entries[tail] <= '{
                arch_rd: alloc.arch_rd,
                new_preg: alloc.new_preg,
                old_preg: alloc.old_preg,
                done: 1'b0
            };
        end
    end

    // Queue pointers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc.alloc) begin
                tail <= tail + 1'b1;
            end
            // One in-order retire per cycle
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc.alloc) - CNT_W'(commit_valid);
        end
    end
endmodule

/* rename_top.sv */
module rename_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  logic [31:0]           inst_word,
    output logic                  inst_ready,
    output logic                  ren_valid,
    output rename_pkg::phys_reg_t ren_rs1_preg,
    output rename_pkg::phys_reg_t ren_rs2_preg,
    output rename_pkg::phys_reg_t ren_rd_preg,
    output rename_pkg::rob_id_t   ren_rob_id,
    input  logic                  done_valid,
    input  rename_pkg::rob_id_t   done_rob_id,
    output logic                  commit_valid,
    output rename_pkg::arch_reg_t commit_arch_rd,
    output rename_pkg::phys_reg_t commit_preg,
    output rename_pkg::phys_reg_t commit_freed_preg
);
    import rename_pkg::*;

    // Rename to alias table
    arch_reg_t rat_rs1;
    arch_reg_t rat_rs2;
    arch_reg_t rat_rd;
    phys_reg_t rat_rs1_preg;
    phys_reg_t rat_rs2_preg;
    phys_reg_t rat_old_preg;
    phys_reg_t rat_new_preg;
    logic rat_we;

    // Pop from rename, push from commit
    free_list_if fl_if ();
    rob_alloc_if rob_if ();

    rename_dispatch dispatch_i (
        .clk(clk),
        .arst_n(arst_n),
        .inst_valid(inst_valid),
        .inst_word(inst_word),
        .inst_ready(inst_ready),
        .ren_valid(ren_valid),
        .ren_rs1_preg(ren_rs1_preg),
        .ren_rs2_preg(ren_rs2_preg),
        .ren_rd_preg(ren_rd_preg),
        .ren_rob_id(ren_rob_id),
        .rat_rs1(rat_rs1),
        .rat_rs2(rat_rs2),
        .rat_rd(rat_rd),
        .rat_rs1_preg(rat_rs1_preg),
        .rat_rs2_preg(rat_rs2_preg),
        .rat_old_preg(rat_old_preg),
        .rat_we(rat_we),
        .rat_new_preg(rat_new_preg),
        .fl(fl_if),
        .rob(rob_if)
    );

    reg_alias_table rat_i (
        .clk(clk),
        .arst_n(arst_n),
        .rs1(rat_rs1),
        .rs2(rat_rs2),
        .rd(rat_rd),
        .rs1_preg(rat_rs1_preg),
        .rs2_preg(rat_rs2_preg),
        .rd_old_preg(rat_old_preg),
        .we(rat_we),
        .new_preg(rat_new_preg)
    );

    // Both sides of the same free-list bundle
    free_list free_list_i (
        .clk(clk),
        .arst_n(arst_n),
        .fl(fl_if),
        .ret(fl_if)
    );

    reorder_buffer rob_i (
        .clk(clk),
        .arst_n(arst_n),
        .alloc(rob_if),
        .fl(fl_if),
        .done_valid(done_valid),
        .done_rob_id(done_rob_id),
        .commit_valid(commit_valid),
        .commit_arch_rd(commit_arch_rd),
        .commit_preg(commit_preg),
        .commit_freed_preg(commit_freed_preg)
    );
endmodule

/* tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end
endmodule

/* tb_rename.sv */
module tb_rename;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam int ROB_ENTRIES = 8;
    localparam int TAG_WORDS = 200;
    localparam int LONG_WORDS = 1500;
    // Reset, the three short tests and the two random streams
    localparam int STIM_CYCLES = 8 + 20 + TAG_WORDS + 40 + 30 + LONG_WORDS;
    localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 100;

    typedef struct packed {
        logic [4:0] rd;
        logic [5:0] new_p;
        logic [5:0] old_p;
        logic [2:0] id;
        logic done;
    } entry_t;

    logic clk;
    logic arst_n;
    logic inst_valid;
    logic [31:0] inst_word;
    logic inst_ready;
    logic ren_valid;
    logic [5:0] ren_rs1_preg;
    logic [5:0] ren_rs2_preg;
    logic [5:0] ren_rd_preg;
    logic [2:0] ren_rob_id;
    logic done_valid;
    logic [2:0] done_rob_id;
    logic commit_valid;
    logic [4:0] commit_arch_rd;
    logic [5:0] commit_preg;
    logic [5:0] commit_freed_preg;

    // Reference model state
    logic [5:0] map [32];
    logic [5:0] fl_q[$];
    entry_t rob_q[$];
    logic [2:0] tail_id;
    logic live;
    logic [63:0] busy;
    logic [63:0] busy_at_ren;

    // Expected DUT outputs for the current cycle
    logic exp_ready;
    logic exp_ren_valid;
    logic [5:0] exp_rs1;
    logic [5:0] exp_rs2;
    logic [5:0] exp_rd;
    logic [2:0] exp_rob_id;
    logic exp_commit;
    logic [4:0] exp_c_rd;
    logic [5:0] exp_c_preg;
    logic [5:0] exp_c_freed;

    // Stimulus control
    logic [31:0] word_q[$];
    bit complete_on;
    bit gap_on;
    bit reverse_done;
    int err_count;
    int tests_run;
    int transfers;
    int commits;
    int cycle_count;
    int start_errs;

    tb_clk_gen clk_gen_i (.clk(clk), .arst_n(arst_n));

    rename_top dut_i (.*);

    task automatic flag_mismatch(input string msg);
        err_count++;
        $display("FAILED at time %0t: %s", $time, msg);
    endtask

    a_ready: assert property (@(posedge clk) disable iff (!arst_n) inst_ready == exp_ready)
        else flag_mismatch($sformatf("inst_ready %0b, expected %0b",
                                     $sampled(inst_ready), $sampled(exp_ready)));
    a_ren_valid: assert property (@(posedge clk) disable iff (!arst_n) ren_valid == exp_ren_valid)
        else flag_mismatch("ren_valid not one cycle after a transfer");
    // Sources, fresh tag and entry number
    a_tags: assert property (@(posedge clk) disable iff (!arst_n)
        ren_valid |-> (ren_rs1_preg == exp_rs1 && ren_rs2_preg == exp_rs2
                       && ren_rd_preg == exp_rd && ren_rob_id == exp_rob_id))
        else flag_mismatch($sformatf("tags p%0d p%0d p%0d rob %0d, expected p%0d p%0d p%0d rob %0d",
            $sampled(ren_rs1_preg), $sampled(ren_rs2_preg), $sampled(ren_rd_preg),
            $sampled(ren_rob_id), exp_rs1, exp_rs2, exp_rd, exp_rob_id));
    a_fresh: assert property (@(posedge clk) disable iff (!arst_n)
        (ren_valid && ren_rd_preg != 6'd0) |-> !busy_at_ren[ren_rd_preg])
        else flag_mismatch($sformatf("p%0d renamed while still live", $sampled(ren_rd_preg)));
    a_commit_valid: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid == exp_commit)
        else flag_mismatch($sformatf("commit_valid %0b, expected %0b",
                                     $sampled(commit_valid), exp_commit));
    a_commit_data: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid |-> (commit_arch_rd == exp_c_rd && commit_preg == exp_c_preg
                          && commit_freed_preg == exp_c_freed))
        else flag_mismatch($sformatf("commit x%0d p%0d freed p%0d, expected x%0d p%0d p%0d",
            $sampled(commit_arch_rd), $sampled(commit_preg), $sampled(commit_freed_preg),
            exp_c_rd, exp_c_preg, exp_c_freed));

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = $urandom;
        // Half OP, rest OP-IMM, LOAD or LUI
        case ($urandom % 6)
            0, 1, 2: w[6:0] = OPC_OP;
            3: w[6:0] = 7'b0010011;
            4: w[6:0] = 7'b0000011;
            default: w[6:0] = 7'b0110111;
        endcase
        return w;
    endfunction

    // One clock edge of the model, then the next inputs
    task automatic advance_cycle();
        logic took;
        logic is_r;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [5:0] rdp;
        entry_t e;
        int cand[$];
        int k;
        took = inst_valid && exp_ready;
        @(posedge clk);
        #1;
        // Oldest done entry leaves, replaced tag back to the free FIFO
        if (exp_commit) begin
            e = rob_q.pop_front();
            commits++;
            if (e.rd != 5'd0) begin
                fl_q.push_back(e.old_p);
                busy[e.old_p] = 1'b0;
            end
        end
        busy_at_ren = busy;
        exp_ren_valid = took;
        if (took) begin
            is_r = (inst_word[6:0] == OPC_OP);
            rs1 = inst_word[19:15];
            rs2 = is_r ? inst_word[24:20] : 5'd0;
            rd = inst_word[11:7];
            // Lookups before this rd's own write
            exp_rs1 = map[rs1];
            exp_rs2 = is_r ? map[rs2] : 6'd0;
            rdp = (rd != 5'd0) ? fl_q.pop_front() : 6'd0;
            exp_rd = rdp;
            exp_rob_id = tail_id;
            rob_q.push_back('{rd: rd, new_p: rdp, old_p: map[rd], id: tail_id, done: 1'b0});
            if (rd != 5'd0) begin
                map[rd] = rdp;
                busy[rdp] = 1'b1;
            end
            tail_id = tail_id + 3'd1;
            transfers++;
        end
        if (done_valid) begin
            foreach (rob_q[i]) begin
                if (rob_q[i].id == done_rob_id) rob_q[i].done = 1'b1;
            end
        end
        live = 1'b1;
        // Word held until taken
        if (took || !inst_valid) begin
            if (word_q.size() != 0 && !(gap_on && $urandom % 4 == 0)) begin
                inst_valid = 1'b1;
                inst_word = word_q.pop_front();
            end else begin
                inst_valid = 1'b0;
            end
        end
        // Completion for one open, not yet done entry
        done_valid = 1'b0;
        if (complete_on && $urandom % 4 != 0) begin
            foreach (rob_q[i]) begin
                if (!rob_q[i].done) cand.push_back(i);
            end
            if (cand.size() != 0) begin
                k = reverse_done ? cand[cand.size() - 1] : cand[$urandom % cand.size()];
                done_valid = 1'b1;
                done_rob_id = rob_q[k].id;
            end
        end
        exp_commit = (rob_q.size() != 0) && rob_q[0].done;
        if (exp_commit) begin
            exp_c_rd = rob_q[0].rd;
            exp_c_preg = rob_q[0].new_p;
            exp_c_freed = rob_q[0].old_p;
        end
        exp_ready = live && (rob_q.size() < ROB_ENTRIES)
                    && (fl_q.size() != 0 || inst_word[11:7] == 5'd0);
    endtask

    task automatic drain();
        while (word_q.size() != 0 || inst_valid || rob_q.size() != 0) advance_cycle();
        repeat (2) advance_cycle();
    endtask

    task automatic report_test(input string name, input int first_err);
        tests_run++;
        $display("test %-16s finished, %0d failed checks", name, err_count - first_err);
    endtask

    // Watchdog
    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h53b5_e027));
        inst_valid = 1'b0;
        inst_word = 32'd0;
        done_valid = 1'b0;
        done_rob_id = 3'd0;
        // Identity map, p32 to p63 free, empty buffer
        for (int i = 0; i < 32; i++) begin
            map[i] = 6'(i);
            fl_q.push_back(6'(32 + i));
        end
        busy = 64'h0000_0000_ffff_ffff;
        busy_at_ren = busy;
        tail_id = 3'd0;
        live = 1'b0;
        {exp_ready, exp_ren_valid, exp_commit} = 3'b000;
        @(posedge arst_n);

        // Idle first, then add x5, x1, x2 takes p32
        start_errs = err_count;
        complete_on = 1'b1;
        repeat (4) advance_cycle();
        word_q.push_back({7'd0, 5'd2, 5'd1, 3'd0, 5'd5, OPC_OP});
        drain();
        report_test("reset_state", start_errs);

        start_errs = err_count;
        gap_on = 1'b1;
        repeat (TAG_WORDS) word_q.push_back(rand_word());
        drain();
        report_test("rename_tags", start_errs);

        // Buffer fills at 8, word 9 waits
        start_errs = err_count;
        complete_on = 1'b0;
        gap_on = 1'b0;
        repeat (12) word_q.push_back(rand_word());
        repeat (20) advance_cycle();
        complete_on = 1'b1;
        drain();
        report_test("back_pressure", start_errs);

        // Youngest completes first
        start_errs = err_count;
        complete_on = 1'b0;
        repeat (ROB_ENTRIES) word_q.push_back(rand_word());
        while (rob_q.size() < ROB_ENTRIES) advance_cycle();
        reverse_done = 1'b1;
        complete_on = 1'b1;
        drain();
        reverse_done = 1'b0;
        report_test("in_order_commit", start_errs);

        start_errs = err_count;
        gap_on = 1'b1;
        repeat (LONG_WORDS) word_q.push_back(rand_word());
        drain();
        report_test("recycling", start_errs);

        $display("tests %0d, failed checks %0d, transfers %0d, commits %0d",
                 tests_run, err_count, transfers, commits);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end
endmodule

/* filelist.f */
+incdir+.
rename_pkg.sv
rename_if.sv
rename_dispatch.sv
reg_alias_table.sv
free_list.sv
reorder_buffer.sv
rename_top.sv
tb_clk_gen.sv
tb_rename.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rename testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f filelist.f --top-module tb_rename -o sim_rename

out="$(./obj_dir/sim_rename)"
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
